// ==== Bender.yml ====
package:
  name: mac_xmit_top

sources:
  - hdl/mac_xmit_pkg.sv
  - hdl/frame_loader.sv
  - hdl/channel_access.sv
  - hdl/xmit_sequencer.sv
  - hdl/mac_xmit_top.sv
  - target: simulation
    files:
      - sim/mac_xmit_checker.sv
      - sim/tb_mac_xmit_top.sv

// ==== hdl/channel_access.sv ====
`timescale 1ns/1ns

module channel_access import mac_xmit_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic enb_out_8,
    input  logic cardet,
    input  logic access_req,
    output logic grant
);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t      state;
    logic [11:0] tick_ct;
    logic [11:0] wait_ticks;
    logic [1:0]  div3;
    logic [4:0]  rand_ct;
    logic        check;

    // carrier is sampled on the last tick of each wait
    assign check = (state == S_WAIT) && enb_out_8 && (tick_ct == wait_ticks - 12'd1);
    assign grant = check && !cardet;

    // pseudo random slot count, advanced every third clock
    always_ff @(posedge clk) begin
        if (rst) begin
            div3    <= '0;
            rand_ct <= '0;
        end else begin
            if (div3 == 2'd2) begin
                div3    <= '0;
                rand_ct <= rand_ct + 1'b1;
            end else begin
                div3 <= div3 + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            tick_ct    <= '0;
            wait_ticks <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    tick_ct    <= '0;
                    wait_ticks <= 12'(DIFS_TICKS);
                    if (access_req) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (check) begin
                        tick_ct <= '0;
                        if (cardet) begin
                            // busy, back off a random number of slots
                            wait_ticks <= 12'(SLOT_TICKS) * (12'(rand_ct) + 12'd1);
                        end else begin
                            state <= S_IDLE;
                        end
                    end else if (enb_out_8) begin
                        tick_ct <= tick_ct + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    a_grant_clear: assert property (@(posedge clk) disable iff (rst)
        grant |-> !cardet);

    // grant only answers a pending request
    a_grant_req: assert property (@(posedge clk) disable iff (rst)
        grant |-> access_req);

endmodule

// ==== hdl/frame_loader.sv ====
`timescale 1ns/1ns

module frame_loader import mac_xmit_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        xvalid,
    input  logic        xsend,
    input  logic [7:0]  uart_in,
    input  logic        xmit_idle,
    output buf_wr_t     buf_wr,
    output logic        xrdy,
    output logic [7:0]  dest_addr,
    output logic [7:0]  frame_type,
    output logic        frame_done,
    output frame_info_t frame_info
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREAMBLE,
        S_SFD,
        S_DEST,
        S_SRC,
        S_TYPE,
        S_PAYLOAD,
        S_DONE
    } state_t;

    state_t                state;
    state_t                next;
    logic [BUF_ADDR_W-1:0] wr_addr;
    logic                  wr_en;
    field_sel_t            sel;

    always_comb begin
        next  = state;
        wr_en = 1'b0;
        sel   = PREAMBLE;
        case (state)
            S_IDLE: begin
                // buffer belongs to the sequencer until it is idle
                if (xmit_idle) begin
                    next = S_PREAMBLE;
                end
            end
            S_PREAMBLE: begin
                wr_en = 1'b1;
                if (wr_addr == BUF_ADDR_W'(PREAMBLE_LEN - 1)) begin
                    next = S_SFD;
                end
            end
            S_SFD: begin
                wr_en = 1'b1;
                sel   = SFD;
                next  = S_DEST;
            end
            S_DEST: begin
                sel = DEST;
                if (xvalid) begin
                    wr_en = 1'b1;
                    next  = S_SRC;
                end
            end
            S_SRC: begin
                // own address, no host byte needed
                wr_en = 1'b1;
                sel   = SRC_MAC;
                next  = S_TYPE;
            end
            S_TYPE: begin
                sel = FTYPE;
                if (xvalid) begin
                    wr_en = 1'b1;
                    next  = S_PAYLOAD;
                end
            end
            S_PAYLOAD: begin
                sel = PAYLOAD;
                if (xvalid) begin
                    wr_en = 1'b1;
                    // xsend marks the last byte, else stop at a full payload
                    if (xsend || wr_addr == BUF_ADDR_W'(HDR_LEN + MAX_PAYLOAD - 1)) begin
                        next = S_DONE;
                    end
                end
            end
            S_DONE: begin
                next = S_IDLE;
            end
            default: begin
                next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            wr_addr <= '0;
        end else begin
            state <= next;
            if (state == S_IDLE) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // header fields kept for the top level and the sequencer
    always_ff @(posedge clk) begin
        if (state == S_DEST && xvalid) begin
            dest_addr <= uart_in;
        end
        if (state == S_TYPE && xvalid) begin
            frame_type <= uart_in;
        end
    end

    assign buf_wr.en   = wr_en;
    assign buf_wr.addr = wr_addr;
    assign buf_wr.sel  = sel;

    assign xrdy = (state == S_DEST) || (state == S_TYPE) || (state == S_PAYLOAD);

    // address after the last write equals the byte count
    assign frame_done       = (state == S_DONE);
    assign frame_info.len   = wr_addr;
    assign frame_info.ftype = frame_type;

    a_wr_addr_range: assert property (@(posedge clk) disable iff (rst)
        buf_wr.en |-> buf_wr.addr < BUF_ADDR_W'(HDR_LEN + MAX_PAYLOAD));

endmodule

// ==== hdl/mac_xmit_pkg.sv ====
package mac_xmit_pkg;

    // frame format
    localparam int PREAMBLE_LEN = 2;
    // start byte, destination, source and type follow the preamble
    localparam int HDR_LEN      = PREAMBLE_LEN + 4;
    localparam int MAX_PAYLOAD  = 256;
    localparam int BUF_ADDR_W   = 9;
    localparam int CRC_BYTES    = 2;
    // preamble and start byte are outside the check field
    localparam int CRC_SKIP     = PREAMBLE_LEN + 1;

    // timing, in ticks of the 8x baud strobe
    localparam int DIFS_TICKS   = 640;
    localparam int SLOT_TICKS   = 64;
    localparam int ACK_TICKS    = 640;

    // total sends of one acknowledged frame
    localparam int MAX_ATTEMPTS = 5;

    // frame types with special handling
    localparam logic [7:0] FTYPE_NO_CRC  = 8'h30;
    localparam logic [7:0] FTYPE_ACK_REQ = 8'h32;

    // byte source for the buffer mux
    typedef enum logic [2:0] {
        PREAMBLE,
        SFD,
        DEST,
        SRC_MAC,
        FTYPE,
        PAYLOAD
    } field_sel_t;

    // buffer write port
    typedef struct packed {
        logic                  en;
        logic [BUF_ADDR_W-1:0] addr;
        field_sel_t            sel;
    } buf_wr_t;

    // buffer read port, data returns one cycle later
    typedef struct packed {
        logic                  en;
        logic [BUF_ADDR_W-1:0] addr;
    } buf_rd_t;

    // handed from loader to sequencer with frame_done
    typedef struct packed {
        logic [BUF_ADDR_W-1:0] len;
        logic [7:0]            ftype;
    } frame_info_t;

endpackage

// ==== hdl/mac_xmit_top.sv ====
`timescale 1ns/1ns

module mac_xmit_top import mac_xmit_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       enb_out_8,
    input  logic       xvalid,
    input  logic       xsend,
    input  logic [7:0] uart_in,
    input  logic [7:0] mac,
    input  logic       cardet,
    input  logic       mx_rdy,
    input  logic       ack_received,
    output logic       xrdy,
    output logic       xbusy,
    output buf_wr_t    buf_wr,
    output buf_rd_t    buf_rd,
    output logic [7:0] dest_addr,
    output logic [7:0] frame_type,
    output logic       mx_valid,
    output logic       crc_en,
    output logic       crc_clr,
    output logic       crc_xmit,
    output logic       xerrcnt
);

    logic        frame_done;
    frame_info_t frame_info;
    logic        xmit_idle;
    logic        access_req;
    logic        grant;

    frame_loader frame_loader_i (
        .clk        (clk),
        .rst        (rst),
        .xvalid     (xvalid),
        .xsend      (xsend),
        .uart_in    (uart_in),
        .xmit_idle  (xmit_idle),
        .buf_wr     (buf_wr),
        .xrdy       (xrdy),
        .dest_addr  (dest_addr),
        .frame_type (frame_type),
        .frame_done (frame_done),
        .frame_info (frame_info)
    );

    channel_access channel_access_i (
        .clk        (clk),
        .rst        (rst),
        .enb_out_8  (enb_out_8),
        .cardet     (cardet),
        .access_req (access_req),
        .grant      (grant)
    );

    xmit_sequencer xmit_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .frame_done   (frame_done),
        .frame_info   (frame_info),
        .grant        (grant),
        .mx_rdy       (mx_rdy),
        .enb_out_8    (enb_out_8),
        .ack_received (ack_received),
        .access_req   (access_req),
        .xmit_idle    (xmit_idle),
        .mx_valid     (mx_valid),
        .crc_en       (crc_en),
        .crc_clr      (crc_clr),
        .crc_xmit     (crc_xmit),
        .xerrcnt      (xerrcnt),
        .buf_rd       (buf_rd)
    );

    assign xbusy = !xmit_idle;

    // the external mux copies our address in the source byte cycle
    a_mac_known: assert property (@(posedge clk) disable iff (rst)
        buf_wr.en && buf_wr.sel == SRC_MAC |-> !$isunknown(mac));

endmodule

// ==== hdl/xmit_sequencer.sv ====
`timescale 1ns/1ns

module xmit_sequencer import mac_xmit_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        frame_done,
    input  frame_info_t frame_info,
    input  logic        grant,
    input  logic        mx_rdy,
    input  logic        enb_out_8,
    input  logic        ack_received,
    output logic        access_req,
    output logic        xmit_idle,
    output logic        mx_valid,
    output logic        crc_en,
    output logic        crc_clr,
    output logic        crc_xmit,
    output logic        xerrcnt,
    output buf_rd_t     buf_rd
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_GRANT,
        S_SEND,
        S_CRC,
        S_ACK_WAIT
    } state_t;

    state_t                state;
    state_t                after_send;
    frame_info_t           info;
    logic [BUF_ADDR_W-1:0] rd_addr;
    logic [BUF_ADDR_W-1:0] beat_ct;
    logic [1:0]            trl_ct;
    logic [9:0]            ack_ct;
    logic [2:0]            attempt_ct;
    logic                  accept;
    logic                  issue;
    logic                  last_beat;
    logic                  last_trl;
    logic                  ack_timeout;

    assign accept = mx_valid && mx_rdy;

    // read ahead only when the output register is free or draining
    assign issue = (state == S_SEND) && (rd_addr < info.len) && (!mx_valid || mx_rdy);

    assign last_beat = (state == S_SEND) && accept && (beat_ct == info.len - 1'b1);
    assign last_trl  = (state == S_CRC) && accept && (trl_ct == 2'(CRC_BYTES - 1));

    assign ack_timeout = (state == S_ACK_WAIT) && !ack_received && enb_out_8
                         && (ack_ct == 10'(ACK_TICKS - 1));

    // only acknowledged frames wait for a reply
    assign after_send = (info.ftype == FTYPE_ACK_REQ) ? S_ACK_WAIT : S_IDLE;

    assign buf_rd.en   = issue;
    assign buf_rd.addr = rd_addr;

    assign access_req = (state == S_WAIT_GRANT);
    assign xmit_idle  = (state == S_IDLE);
    assign crc_clr    = (state == S_WAIT_GRANT) && grant;
    assign crc_en     = (state == S_SEND) && accept && (beat_ct >= BUF_ADDR_W'(CRC_SKIP));
    assign crc_xmit   = (state == S_CRC);
    assign xerrcnt    = ack_timeout && (attempt_ct >= 3'(MAX_ATTEMPTS));

    always_ff @(posedge clk) begin
        if (state == S_IDLE && frame_done) begin
            info <= frame_info;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            mx_valid   <= 1'b0;
            rd_addr    <= '0;
            beat_ct    <= '0;
            trl_ct     <= '0;
            ack_ct     <= '0;
            attempt_ct <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    attempt_ct <= '0;
                    if (frame_done) begin
                        state <= S_WAIT_GRANT;
                    end
                end
                S_WAIT_GRANT: begin
                    // every send restarts from address 0
                    rd_addr <= '0;
                    beat_ct <= '0;
                    trl_ct  <= '0;
                    if (grant) begin
                        attempt_ct <= attempt_ct + 1'b1;
                        state      <= S_SEND;
                    end
                end
                S_SEND: begin
                    ack_ct <= '0;
                    if (issue) begin
                        rd_addr  <= rd_addr + 1'b1;
                        mx_valid <= 1'b1;
                    end else if (accept) begin
                        mx_valid <= 1'b0;
                    end
                    if (accept) begin
                        beat_ct <= beat_ct + 1'b1;
                    end
                    if (last_beat) begin
                        if (info.ftype == FTYPE_NO_CRC) begin
                            state <= after_send;
                        end else begin
                            // trailer bytes come from the CRC engine
                            mx_valid <= 1'b1;
                            state    <= S_CRC;
                        end
                    end
                end
                S_CRC: begin
                    ack_ct <= '0;
                    if (accept) begin
                        trl_ct <= trl_ct + 1'b1;
                    end
                    if (last_trl) begin
                        mx_valid <= 1'b0;
                        state    <= after_send;
                    end
                end
                S_ACK_WAIT: begin
                    if (ack_received) begin
                        state <= S_IDLE;
                    end else if (ack_timeout) begin
                        if (attempt_ct < 3'(MAX_ATTEMPTS)) begin
                            state <= S_WAIT_GRANT;
                        end else begin
                            state <= S_IDLE;
                        end
                    end else if (enb_out_8) begin
                        ack_ct <= ack_ct + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // held beat keeps its data and address until taken
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        mx_valid && !mx_rdy |=> mx_valid && $stable(buf_rd.addr));

    a_crc_excl: assert property (@(posedge clk) disable iff (rst)
        !(crc_en && crc_xmit));

endmodule

// ==== mac_xmit_top.f ====
hdl/mac_xmit_pkg.sv
hdl/frame_loader.sv
hdl/channel_access.sv
hdl/xmit_sequencer.sv
hdl/mac_xmit_top.sv
sim/mac_xmit_checker.sv
sim/tb_mac_xmit_top.sv

// ==== sim/mac_xmit_checker.sv ====
`timescale 1ns/1ns

module mac_xmit_checker import mac_xmit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cardet,
    input  logic    xrdy,
    input  logic    xvalid,
    input  logic    xbusy,
    input  logic    mx_valid,
    input  logic    mx_rdy,
    input  logic    crc_en,
    input  logic    crc_clr,
    input  logic    crc_xmit,
    input  logic    xerrcnt,
    input  buf_wr_t buf_wr,
    input  buf_rd_t buf_rd,
    output int      errors
);

    initial errors = 0;

    // outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !mx_valid && !crc_xmit && !xerrcnt && !xbusy && !buf_rd.en)
        else begin
            errors++;
            $display("%0t: outputs not idle after reset", $time);
        end

    // held beat keeps its read address
    a_back_pressure: assert property (@(posedge clk) disable iff (rst)
        mx_valid && !mx_rdy |=> mx_valid && $stable(buf_rd.addr))
        else begin
            errors++;
            $display("%0t: beat dropped or read address moved under back-pressure", $time);
        end

    a_crc_en_beat: assert property (@(posedge clk) disable iff (rst)
        crc_en |-> mx_valid && mx_rdy && !crc_xmit)
        else begin
            errors++;
            $display("%0t: crc_en high outside an accepted frame beat", $time);
        end

    a_trailer_no_read: assert property (@(posedge clk) disable iff (rst)
        crc_xmit |-> !buf_rd.en)
        else begin
            errors++;
            $display("%0t: buffer read during the CRC trailer", $time);
        end

    // crc_clr marks the grant, which needs a clear channel
    a_grant_clear: assert property (@(posedge clk) disable iff (rst)
        crc_clr |-> !cardet)
        else begin
            errors++;
            $display("%0t: channel granted while carrier was present", $time);
        end

    a_err_pulse: assert property (@(posedge clk) disable iff (rst)
        xerrcnt |-> xbusy ##1 !xerrcnt)
        else begin
            errors++;
            $display("%0t: xerrcnt is not a single pulse inside a busy period", $time);
        end

    // loader only writes while the sequencer is idle
    a_wr_when_idle: assert property (@(posedge clk) disable iff (rst)
        buf_wr.en |-> !xbusy)
        else begin
            errors++;
            $display("%0t: buffer written while a frame was being sent", $time);
        end

    // host bytes are taken exactly when xrdy meets xvalid
    a_xrdy_wait: assert property (@(posedge clk) disable iff (rst)
        xrdy |-> !xbusy && buf_wr.en == xvalid
                 && (!xvalid || buf_wr.sel inside {DEST, FTYPE, PAYLOAD}))
        else begin
            errors++;
            $display("%0t: xrdy high outside a wait for a host byte", $time);
        end

    a_xrdy_fixed_field: assert property (@(posedge clk) disable iff (rst)
        buf_wr.en && buf_wr.sel inside {PREAMBLE, SFD, SRC_MAC} |-> !xrdy)
        else begin
            errors++;
            $display("%0t: xrdy high while a fixed header byte was written", $time);
        end

endmodule

// ==== sim/tb_mac_xmit_top.sv ====
`timescale 1ns/1ns

module tb_mac_xmit_top import mac_xmit_pkg::*;;

    localparam logic [7:0] MAC_ADDR = 8'hA7;
    localparam logic [7:0] PRE_BYTE = 8'hAA;
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    localparam int         WAIT_MAX = 40000;

    logic clk = 1'b0;
    logic rst, enb_out_8, xvalid, xsend, cardet, mx_rdy, ack_received;
    logic [7:0] uart_in;
    logic [7:0] mac;
    logic xrdy, xbusy, mx_valid, crc_en, crc_clr, crc_xmit, xerrcnt;
    logic [7:0] dest_addr, frame_type;
    buf_wr_t buf_wr;
    buf_rd_t buf_rd;
    int chk_errors;

    logic [7:0]  mem [0:(1 << BUF_ADDR_W) - 1];
    logic [7:0]  rd_data;
    logic [7:0]  exp_frame [0:HDR_LEN + MAX_PAYLOAD - 1];
    logic [15:0] lfsr = 16'd3668;
    int tb_errors = 0;
    int cur_len, wr_idx = 0, beat_idx = 0, sends_done, clr_ct, err_pulses, ticks;
    int busy_falls = 0;
    logic [7:0] cur_type;
    logic busy_q = 1'b0, first_pending = 1'b0, carrier_case = 1'b0;

    always #2 clk = ~clk;

    mac_xmit_top mac_xmit_top_i (.*);

    mac_xmit_checker mac_xmit_checker_i (.*, .errors(chk_errors));

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) s = s ^ 16'hB400;
        return s;
    endfunction

    function automatic field_sel_t sel_for(input int i);
        if (i < PREAMBLE_LEN) return PREAMBLE;
        if (i == PREAMBLE_LEN) return SFD;
        if (i == PREAMBLE_LEN + 1) return DEST;
        if (i == PREAMBLE_LEN + 2) return SRC_MAC;
        if (i == PREAMBLE_LEN + 3) return FTYPE;
        return PAYLOAD;
    endfunction

    task automatic mismatch(input string name, input int got, input int exp);
        tb_errors++;
        $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic give_up(input string what);
        $display("timeout waiting for %s, %0d check and %0d assertion errors",
                 what, tb_errors, chk_errors);
        $display("Simulation failed");
        $finish;
    endtask

    // random ready, tick every other clock
    always @(posedge clk) begin
        #1;
        lfsr      = lfsr_next(lfsr);
        mx_rdy    = lfsr[0];
        enb_out_8 = ~enb_out_8;
    end

    // buffer mux and buffer
    always @(posedge clk) begin
        if (buf_wr.en) begin
            case (buf_wr.sel)
                PREAMBLE: mem[buf_wr.addr] <= PRE_BYTE;
                SFD:      mem[buf_wr.addr] <= SFD_BYTE;
                SRC_MAC:  mem[buf_wr.addr] <= MAC_ADDR;
                default:  mem[buf_wr.addr] <= uart_in;
            endcase
        end
        if (buf_rd.en) rd_data <= mem[buf_rd.addr];
    end

    // write order, read-out and timing scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            busy_q <= xbusy;
            if (!xbusy && busy_q) busy_falls++;
            if (enb_out_8) ticks++;
            if (xerrcnt) err_pulses++;
            if (buf_wr.en) begin
                assert (buf_wr.addr == wr_idx) else mismatch("buf_wr.addr", buf_wr.addr, wr_idx);
                assert (buf_wr.sel == sel_for(wr_idx))
                    else mismatch("buf_wr.sel", buf_wr.sel, sel_for(wr_idx));
                wr_idx++;
            end
            if (xbusy && !busy_q) begin
                assert (wr_idx == HDR_LEN + cur_len)
                    else mismatch("write count", wr_idx, HDR_LEN + cur_len);
                assert (dest_addr == exp_frame[PREAMBLE_LEN + 1])
                    else mismatch("dest_addr", dest_addr, exp_frame[PREAMBLE_LEN + 1]);
                assert (frame_type == cur_type) else mismatch("frame_type", frame_type, cur_type);
                wr_idx = 0;
                ticks = 0;
                first_pending = 1'b1;
            end
            if (crc_clr) begin
                clr_ct++;
                beat_idx = 0;
            end
            if (mx_valid && mx_rdy) begin
                if (first_pending) begin
                    first_pending = 1'b0;
                    assert (ticks >= DIFS_TICKS + (carrier_case ? SLOT_TICKS : 0))
                        else mismatch("ticks before first beat", ticks,
                                      DIFS_TICKS + (carrier_case ? SLOT_TICKS : 0));
                end
                if (crc_xmit) begin
                    assert (cur_type != FTYPE_NO_CRC && beat_idx >= HDR_LEN + cur_len
                            && beat_idx < HDR_LEN + cur_len + CRC_BYTES)
                        else mismatch("trailer beat index", beat_idx, HDR_LEN + cur_len);
                    if (beat_idx == HDR_LEN + cur_len + CRC_BYTES - 1) sends_done++;
                end else begin
                    assert (rd_data == exp_frame[beat_idx])
                        else mismatch("beat data", rd_data, exp_frame[beat_idx]);
                    assert (crc_en == (beat_idx >= CRC_SKIP))
                        else mismatch("crc_en", crc_en, beat_idx >= CRC_SKIP);
                    if (cur_type == FTYPE_NO_CRC && beat_idx == HDR_LEN + cur_len - 1) begin
                        sends_done++;
                    end
                end
                beat_idx++;
            end
        end
    end

    task automatic put_byte(input logic [7:0] b, input logic last);
        int t;
        t = 0;
        while (!xrdy) begin
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_MAX) give_up("xrdy");
        end
        xvalid  = 1'b1;
        uart_in = b;
        xsend   = last;
        @(posedge clk);
        #1;
        xvalid = 1'b0;
        xsend  = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic [7:0] ftype, input logic busy_air,
                              input logic give_ack);
        int t, exp_sends;
        logic [7:0] dest;
        dest = 8'(len * 3 + 1);
        exp_sends = (ftype == FTYPE_ACK_REQ && !give_ack) ? MAX_ATTEMPTS : 1;
        cur_len = len;
        cur_type = ftype;
        carrier_case = busy_air;
        sends_done = 0;
        clr_ct = 0;
        err_pulses = 0;
        busy_falls = 0;
        for (int i = 0; i < PREAMBLE_LEN; i++) exp_frame[i] = PRE_BYTE;
        exp_frame[PREAMBLE_LEN]     = SFD_BYTE;
        exp_frame[PREAMBLE_LEN + 1] = dest;
        exp_frame[PREAMBLE_LEN + 2] = MAC_ADDR;
        exp_frame[PREAMBLE_LEN + 3] = ftype;
        for (int i = 0; i < len; i++) exp_frame[HDR_LEN + i] = 8'(i * 7 + len);
        put_byte(dest, 1'b0);
        put_byte(ftype, 1'b0);
        for (int i = 0; i < len; i++) put_byte(exp_frame[HDR_LEN + i], i == len - 1);
        // carrier across the first interframe check
        if (busy_air) begin
            cardet = 1'b1;
            repeat (1400) @(posedge clk);
            #1;
            cardet = 1'b0;
        end
        if (give_ack) begin
            t = 0;
            while (sends_done < 1) begin
                @(posedge clk);
                #1;
                t++;
                if (t > WAIT_MAX) give_up("end of send");
            end
            repeat (3) @(posedge clk);
            #1;
            ack_received = 1'b1;
            @(posedge clk);
            #1;
            ack_received = 1'b0;
        end
        // busy period of this frame has ended
        t = 0;
        while (busy_falls == 0) begin
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_MAX) give_up("xbusy to fall");
        end
        assert (sends_done == exp_sends) else mismatch("sends", sends_done, exp_sends);
        assert (clr_ct == exp_sends) else mismatch("crc_clr pulses", clr_ct, exp_sends);
        assert (err_pulses == (exp_sends == MAX_ATTEMPTS))
            else mismatch("xerrcnt pulses", err_pulses, exp_sends == MAX_ATTEMPTS);
    endtask

    initial begin
        rst = 1'b1;
        enb_out_8 = 1'b0;
        xvalid = 1'b0;
        xsend = 1'b0;
        uart_in = 8'h00;
        mac = MAC_ADDR;
        cardet = 1'b0;
        mx_rdy = 1'b0;
        ack_received = 1'b0;
        cur_len = 0;
        cur_type = 8'h00;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        send_frame(5, 8'h31, 1'b0, 1'b0);
        send_frame(1, FTYPE_NO_CRC, 1'b0, 1'b0);
        send_frame(12, FTYPE_ACK_REQ, 1'b0, 1'b1);
        send_frame(3, 8'h31, 1'b1, 1'b0);
        send_frame(4, FTYPE_ACK_REQ, 1'b0, 1'b0);
        send_frame(MAX_PAYLOAD, 8'h31, 1'b0, 1'b0);
        repeat (4) @(posedge clk);
        $display("check errors %0d, assertion errors %0d", tb_errors, chk_errors);
        if (tb_errors == 0 && chk_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
